// File: source/keccak_pkg.sv
`default_nettype none

package keccak_pkg;

    // Lane geometry
    localparam int w = 64;
    localparam int w_byte_size = w / 8;

    // Enough bits to index a byte inside one lane
    localparam int w_byte_width = $clog2(w_byte_size);

    // Rate of each SHAKE variant in bits
    localparam int RATE_SHAKE128 = 1344;
    localparam int RATE_SHAKE256 = 1088;

    // Lane counter width, wide enough for the larger rate
    localparam int lane_count_width = 5;

    // Whole lanes that fit in one rate block
    localparam logic [lane_count_width-1:0] LANES_SHAKE128 =
        lane_count_width'(RATE_SHAKE128 / w);
    localparam logic [lane_count_width-1:0] LANES_SHAKE256 =
        lane_count_width'(RATE_SHAKE256 / w);

endpackage

`default_nettype wire

// File: source/dump_pkg.sv
`default_nettype none

package dump_pkg;

    // Requested output length is given in bits
    localparam int output_size_width = 32;

    // Same length counted in bytes (drops the three bit-within-byte bits)
    localparam int byte_count_width = output_size_width - 3;

    // Same length counted in whole lanes
    localparam int lane_total_width = byte_count_width - keccak_pkg::w_byte_width;

    // Output function selected by the request
    typedef enum logic [1:0] {
        SHAKE128_MODE = 2'b00,
        SHAKE256_MODE = 2'b01
    } dump_mode_e;

    // Controller states
    typedef enum logic [1:0] {
        IDLE       = 2'b00,
        WAIT_BLOCK = 2'b01,
        LOAD       = 2'b10,
        SHIFT      = 2'b11
    } dump_state_e;

    // Squeeze request, sampled on start
    typedef struct packed {
        logic [output_size_width-1:0] output_size;
        dump_mode_e                   mode;
    } dump_request_t;

    // Strobes from the controller into the datapath
    typedef struct packed {
        logic intermediate_we;
        logic buffer_we;
        logic shift_en;
        logic tracker_load;
        logic request_load;
    } dump_ctrl_t;

    // Datapath flags seen by the controller
    typedef struct packed {
        logic buffer_empty;
        logic last_lane;
        logic request_exhausted;
    } dump_status_t;

endpackage

`default_nettype wire

// File: source/piso_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module piso_buffer (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 write_enable,
    input  logic                                 shift_enable,
    input  logic [keccak_pkg::RATE_SHAKE128-1:0] data_in,
    output logic [keccak_pkg::w-1:0]             data_out
);

    // One entry per lane, lane 0 sits at the output end
    logic [keccak_pkg::LANES_SHAKE128-1:0][keccak_pkg::w-1:0] lanes;

    always_ff @(posedge clk) begin
        if (rst) begin
            lanes <= '0;
        end else if (write_enable) begin
            // Parallel load of a whole rate block
            lanes <= data_in;
        end else if (shift_enable) begin
            // Move every lane one step toward lane 0, zero fill at the top
            lanes <= {{keccak_pkg::w{1'b0}}, lanes[keccak_pkg::LANES_SHAKE128-1:1]};
        end
    end

    // Head of the buffer
    assign data_out = lanes[0];

endmodule

`default_nettype wire

// File: source/output_length_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module output_length_tracker (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                request_load,
    input  dump_pkg::dump_request_t             request,
    input  logic                                block_load,
    input  logic                                shift_en,
    output logic                                last_lane,
    output logic                                buffer_empty,
    output logic                                request_exhausted,
    output logic [keccak_pkg::w_byte_width-1:0] partial_bytes
);

    logic [dump_pkg::byte_count_width-1:0]   bytes_left;
    dump_pkg::dump_mode_e                    mode;
    logic [keccak_pkg::lane_count_width-1:0] lanes_left;
    logic [keccak_pkg::lane_count_width-1:0] full_lanes;
    logic [dump_pkg::lane_total_width:0]     lanes_owed;
    logic                                    tail_nonzero;

    // Block size for the active mode
    assign full_lanes = (mode == dump_pkg::SHAKE256_MODE) ? keccak_pkg::LANES_SHAKE256
                                                         : keccak_pkg::LANES_SHAKE128;

    // Remaining request in lanes, rounded up
    assign tail_nonzero = |bytes_left[keccak_pkg::w_byte_width-1:0];
    assign lanes_owed =
        {1'b0, bytes_left[dump_pkg::byte_count_width-1:keccak_pkg::w_byte_width]} +
        {{dump_pkg::lane_total_width{1'b0}}, tail_nonzero};

    always_ff @(posedge clk) begin
        if (rst) begin
            bytes_left <= '0;
            mode       <= dump_pkg::SHAKE128_MODE;
            lanes_left <= '0;
        end else begin
            if (request_load) begin
                // Bits to bytes
                bytes_left <= request.output_size[dump_pkg::output_size_width-1:3];
                mode       <= request.mode;
            end else if (shift_en) begin
                if (bytes_left > keccak_pkg::w_byte_size) begin
                    bytes_left <= bytes_left -
                                  dump_pkg::byte_count_width'(keccak_pkg::w_byte_size);
                end else begin
                    bytes_left <= '0;
                end
            end

            // Final block of a request may be shorter than the rate
            if (block_load) begin
                if (lanes_owed < full_lanes) begin
                    lanes_left <= lanes_owed[keccak_pkg::lane_count_width-1:0];
                end else begin
                    lanes_left <= full_lanes;
                end
            end else if (shift_en && !buffer_empty) begin
                lanes_left <= lanes_left - 1'b1;
            end
        end
    end

    assign buffer_empty      = (lanes_left == '0);
    assign last_lane         = (lanes_left == keccak_pkg::lane_count_width'(1));
    assign request_exhausted = (bytes_left == '0);

    // Valid bytes of the head lane when it ends the request short of a full lane
    assign partial_bytes = (bytes_left < keccak_pkg::w_byte_size)
                         ? bytes_left[keccak_pkg::w_byte_width-1:0] : '0;

endmodule

`default_nettype wire

// File: source/dump_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module dump_datapath (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [keccak_pkg::RATE_SHAKE128-1:0] rate_block,
    input  dump_pkg::dump_request_t              request,
    input  dump_pkg::dump_ctrl_t                 ctrl,
    output dump_pkg::dump_status_t               status,
    output logic [keccak_pkg::w-1:0]             data_out
);

    logic [keccak_pkg::RATE_SHAKE128-1:0] intermediate_block;
    logic [keccak_pkg::w-1:0]             head_lane;
    logic [keccak_pkg::w_byte_width-1:0]  partial_bytes;
    logic                                 buffer_empty;
    logic                                 last_lane;
    logic                                 request_exhausted;
    logic                                 mask_active;

    // Holding register, lets the next block wait while the buffer drains
    always_ff @(posedge clk) begin
        if (ctrl.intermediate_we) begin
            intermediate_block <= rate_block;
        end
    end

    piso_buffer u_piso_buffer (
        .clk          (clk),
        .rst          (rst),
        .write_enable (ctrl.buffer_we),
        .shift_enable (ctrl.shift_en),
        .data_in      (intermediate_block),
        .data_out     (head_lane)
    );

    output_length_tracker u_output_length_tracker (
        .clk               (clk),
        .rst               (rst),
        .request_load      (ctrl.request_load),
        .request           (request),
        .block_load        (ctrl.tracker_load),
        .shift_en          (ctrl.shift_en),
        .last_lane         (last_lane),
        .buffer_empty      (buffer_empty),
        .request_exhausted (request_exhausted),
        .partial_bytes     (partial_bytes)
    );

    assign status = '{
        buffer_empty:      buffer_empty,
        last_lane:         last_lane,
        request_exhausted: request_exhausted
    };

    // Only the request's closing lane can be short
    assign mask_active = last_lane && (partial_bytes != '0);

    // Byte 0 is the least significant byte of the lane
    always_comb begin
        for (int i = 0; i < keccak_pkg::w_byte_size; i++) begin
            if (mask_active && (i >= partial_bytes)) begin
                data_out[i*8 +: 8] = 8'h00;
            end else begin
                data_out[i*8 +: 8] = head_lane[i*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/dump_control.sv
`timescale 1ns/100ps
`default_nettype none

module dump_control (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   block_valid,
    output logic                   block_ready,
    input  dump_pkg::dump_status_t status,
    output dump_pkg::dump_ctrl_t   ctrl,
    output logic                   data_valid,
    output logic                   done
);

    dump_pkg::dump_state_e state;
    dump_pkg::dump_state_e state_next;
    logic                  intermediate_full;
    logic                  block_accept;

    // Room for one more block only while a request still wants bytes
    assign block_ready = (state != dump_pkg::IDLE) && !intermediate_full &&
                         !status.request_exhausted;
    assign block_accept = block_valid && block_ready;

    always_comb begin
        ctrl                 = '0;
        ctrl.intermediate_we = block_accept;
        done                 = 1'b0;
        state_next           = state;

        case (state)
            dump_pkg::IDLE: begin
                if (start) begin
                    ctrl.request_load = 1'b1;
                    state_next        = dump_pkg::WAIT_BLOCK;
                end
            end

            dump_pkg::WAIT_BLOCK: begin
                if (status.request_exhausted) begin
                    done       = 1'b1;
                    state_next = dump_pkg::IDLE;
                end else if (block_accept) begin
                    state_next = dump_pkg::LOAD;
                end
            end

            // Intermediate register is full here
            dump_pkg::LOAD: begin
                if (status.request_exhausted) begin
                    // Surplus block, dropped with the request
                    done       = 1'b1;
                    state_next = dump_pkg::IDLE;
                end else if (status.buffer_empty) begin
                    ctrl.buffer_we    = 1'b1;
                    ctrl.tracker_load = 1'b1;
                    state_next        = dump_pkg::SHIFT;
                end
            end

            dump_pkg::SHIFT: begin
                ctrl.shift_en = !status.buffer_empty;
                if (status.last_lane) begin
                    // Next block may already be waiting, or arrive this cycle
                    if (intermediate_full || block_accept) begin
                        state_next = dump_pkg::LOAD;
                    end else begin
                        state_next = dump_pkg::WAIT_BLOCK;
                    end
                end
            end

            default: begin
                state_next = dump_pkg::IDLE;
            end
        endcase
    end

    // One valid per lane leaving the buffer
    assign data_valid = ctrl.shift_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= dump_pkg::IDLE;
            intermediate_full <= 1'b0;
        end else begin
            state <= state_next;
            if (done) begin
                intermediate_full <= 1'b0;
            end else if (ctrl.intermediate_we) begin
                intermediate_full <= 1'b1;
            end else if (ctrl.buffer_we) begin
                intermediate_full <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/dump_unit.sv
`timescale 1ns/100ps
`default_nettype none

module dump_unit (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start,
    input  dump_pkg::dump_request_t              request,
    input  logic                                 block_valid,
    input  logic [keccak_pkg::RATE_SHAKE128-1:0] rate_block,
    output logic                                 block_ready,
    output logic [keccak_pkg::w-1:0]             data_out,
    output logic                                 data_valid,
    output logic                                 done
);

    dump_pkg::dump_ctrl_t   ctrl;
    dump_pkg::dump_status_t status;

    // Sequencing
    dump_control u_dump_control (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .block_valid (block_valid),
        .block_ready (block_ready),
        .status      (status),
        .ctrl        (ctrl),
        .data_valid  (data_valid),
        .done        (done)
    );

    // Block storage, lane counting and output masking
    dump_datapath u_dump_datapath (
        .clk        (clk),
        .rst        (rst),
        .rate_block (rate_block),
        .request    (request),
        .ctrl       (ctrl),
        .status     (status),
        .data_out   (data_out)
    );

endmodule

`default_nettype wire

// File: tb/dump_unit_properties.sv
`timescale 1ns/100ps
`default_nettype none

module dump_unit_properties (
    input logic clk,
    input logic rst,
    input logic start,
    input logic block_ready,
    input logic data_valid,
    input logic done
);

    // Failed checks, read back by the testbench
    int failure_count = 0;

    // Outputs quiet in the cycle after a reset edge
    reset_quiet: assert property (@(posedge clk)
        rst |=> (!data_valid && !done && !block_ready))
    else begin
        $error("outputs active after reset");
        failure_count++;
    end

    // done comes one cycle after the final lane
    done_follows_lane: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(data_valid))
    else begin
        $error("done without a lane in the previous cycle");
        failure_count++;
    end

    done_single_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
    else begin
        $error("done held for more than one cycle");
        failure_count++;
    end

    no_lane_with_done: assert property (@(posedge clk) disable iff (rst)
        data_valid |-> !done)
    else begin
        $error("lane and done in the same cycle");
        failure_count++;
    end

    // Back in IDLE, no blocks taken until a new start
    idle_after_done: assert property (@(posedge clk) disable iff (rst)
        (done ##1 !start) |=> (!block_ready && !data_valid))
    else begin
        $error("block_ready or data_valid high while idle");
        failure_count++;
    end

endmodule

`default_nettype wire

// File: tb/dump_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dump_unit_tb;

    // Lanes of all tests together, sets the watchdog limit
    localparam int total_test_lanes = 21 + 40 + 13 + 84 + 19 + 26;
    localparam int timeout_cycles = total_test_lanes * 4 + 200;

    logic                                 clk;
    logic                                 rst;
    logic                                 start;
    dump_pkg::dump_request_t              request;
    logic                                 block_valid;
    logic [keccak_pkg::RATE_SHAKE128-1:0] rate_block;
    logic                                 block_ready;
    logic [keccak_pkg::w-1:0]             data_out;
    logic                                 data_valid;
    logic                                 done;

    logic [31:0]              lcg_state;
    logic [keccak_pkg::w-1:0] expected_lanes [$];
    string                    test_name;
    int                       lanes_seen;
    int                       stall_cycles;

    dump_unit u_dump_unit (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .request     (request),
        .block_valid (block_valid),
        .rate_block  (rate_block),
        .block_ready (block_ready),
        .data_out    (data_out),
        .data_valid  (data_valid),
        .done        (done)
    );

    bind dump_unit dump_unit_properties u_properties (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .block_ready (block_ready),
        .data_valid  (data_valid),
        .done        (done)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Bytes at index count and above become zero
    function automatic logic [keccak_pkg::w-1:0] keep_low_bytes(
        input logic [keccak_pkg::w-1:0] lane, input int count);
        logic [keccak_pkg::w-1:0] result;
        result = '0;
        for (int k = 0; k < count; k++) begin
            result[k*8 +: 8] = lane[k*8 +: 8];
        end
        return result;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic run_request(input string name, input dump_pkg::dump_mode_e mode,
                               input int byte_len, input int gap);
        logic [keccak_pkg::RATE_SHAKE128-1:0] blocks [$];
        logic [keccak_pkg::RATE_SHAKE128-1:0] block;
        logic [keccak_pkg::w-1:0]             lane;
        int                                   lanes_per_block;
        int                                   total_lanes;
        int                                   block_count;
        int                                   tail_bytes;
        int                                   index;
        logic                                 taken;
        lanes_per_block = (mode == dump_pkg::SHAKE256_MODE)
                        ? keccak_pkg::RATE_SHAKE256 / keccak_pkg::w
                        : keccak_pkg::RATE_SHAKE128 / keccak_pkg::w;
        total_lanes = (byte_len + 7) / 8;
        tail_bytes = byte_len % 8;
        block_count = (total_lanes + lanes_per_block - 1) / lanes_per_block;
        test_name = name;
        lanes_seen = 0;
        stall_cycles = 0;

        // Random blocks, and the lane stream they must produce
        for (int b = 0; b < block_count; b++) begin
            for (int l = 0; l < keccak_pkg::RATE_SHAKE128 / keccak_pkg::w; l++) begin
                block[l*keccak_pkg::w +: keccak_pkg::w] = {next_random(), next_random()};
            end
            blocks.push_back(block);
            for (int l = 0; l < lanes_per_block; l++) begin
                index = b * lanes_per_block + l;
                lane = block[l*keccak_pkg::w +: keccak_pkg::w];
                if (index == total_lanes - 1 && tail_bytes != 0) begin
                    lane = keep_low_bytes(lane, tail_bytes);
                end
                if (index < total_lanes) begin
                    expected_lanes.push_back(lane);
                end
            end
        end

        @(posedge clk);
        start <= 1'b1;
        request.output_size <= 32'(byte_len * 8);
        request.mode <= mode;
        @(posedge clk);
        start <= 1'b0;

        foreach (blocks[b]) begin
            if (gap != 0) begin
                block_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            block_valid <= 1'b1;
            rate_block <= blocks[b];
            do begin
                @(negedge clk);
                taken = block_ready;
                if (!taken) begin
                    stall_cycles++;
                end
                @(posedge clk);
            end while (!taken);
        end
        block_valid <= 1'b0;

        do begin
            @(negedge clk);
        end while (!done);
        assert (lanes_seen == total_lanes)
        else abort_run($sformatf("[ERROR] %s: lane count expected %0d actual %0d",
                                 test_name, total_lanes, lanes_seen));
    endtask

    // Scoreboard, one expected lane per data_valid
    always @(negedge clk) begin : scoreboard
        logic [keccak_pkg::w-1:0] expected;
        if (!rst && data_valid) begin
            assert (expected_lanes.size() != 0)
            else abort_run($sformatf("Lane out of %s with no lane left to send", test_name));
            expected = expected_lanes.pop_front();
            assert (data_out == expected)
            else abort_run($sformatf("[ERROR] %s: lane %0d expected %h actual %h",
                                     test_name, lanes_seen, expected, data_out));
            lanes_seen++;
        end
        if (u_dump_unit.u_properties.failure_count != 0) begin
            abort_run("A port property of the DUT failed");
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        abort_run("Run timed out waiting for the DUT to finish");
    end

    initial begin
        lcg_state = 32'hb3c9aa74;
        rst = 1'b1;
        start = 1'b0;
        request = '0;
        block_valid = 1'b0;
        rate_block = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Idle after reset, nothing offered yet
        repeat (3) @(negedge clk);
        assert (!block_ready && !data_valid && !done)
        else abort_run("Outputs not idle after reset");

        run_request("shake128_full_block", dump_pkg::SHAKE128_MODE, 168, 2);
        run_request("shake256_three_blocks", dump_pkg::SHAKE256_MODE, 320, 3);
        run_request("shake128_partial_lane", dump_pkg::SHAKE128_MODE, 100, 1);
        run_request("back_pressure", dump_pkg::SHAKE128_MODE, 672, 0);
        assert (stall_cycles > 0)
        else abort_run("block_ready never dropped with blocks offered every cycle");

        // Back to back, second request starts right after done
        run_request("shake256_then", dump_pkg::SHAKE256_MODE, 150, 1);
        run_request("then_shake128", dump_pkg::SHAKE128_MODE, 203, 0);

        repeat (5) @(posedge clk);
        if (u_dump_unit.u_properties.failure_count == 0 && expected_lanes.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run("Lanes left over or port properties failed at end of run");
        end
    end

endmodule

`default_nettype wire

// File: all.f
source/keccak_pkg.sv
source/dump_pkg.sv
source/piso_buffer.sv
source/output_length_tracker.sv
source/dump_datapath.sv
source/dump_control.sv
source/dump_unit.sv
tb/dump_unit_properties.sv
tb/dump_unit_tb.sv
